// ==== flist.f ====
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/ir_decode.sv
hdl/register_file.sv
hdl/alu.sv
hdl/datapath.sv
hdl/control_unit.sv
hdl/cpu_top.sv
tests/cpu_assert.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  isa_pkg::alu_op_e alu_op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [63:0]      c
);

    logic        [31:0] r;      // narrow result zero-extended into c
    logic        [4:0]  shamt;
    logic signed [63:0] prod;
    logic signed [63:0] sra;

    assign shamt = b[4:0];
    assign prod  = $signed(a) * $signed(b);
    assign sra   = $signed({{32{a[31]}}, a}) >>> shamt;

    always_comb begin
        case (alu_op)
            isa_pkg::alu_add: r = a + b;
            isa_pkg::alu_sub: r = a - b;
            isa_pkg::alu_and: r = a & b;
            isa_pkg::alu_or:  r = a | b;
            isa_pkg::alu_shl: r = a << shamt;
            isa_pkg::alu_shr: r = a >> shamt;
            isa_pkg::alu_neg: r = 32'd0 - b;
            isa_pkg::alu_not: r = ~b;
            default:          r = b;
        endcase
    end

    always_comb begin
        case (alu_op)
            isa_pkg::alu_mul:  c = prod;
            isa_pkg::alu_shra: c = sra;   // sign fills the upper word
            default:           c = {32'd0, r};
        endcase
    end

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ns

module control_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  isa_pkg::opcode_e   opcode,
    input  logic               con_flag,
    input  logic               wb_ack,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output ctrl_pkg::bus_src_e bus_src,
    output ctrl_pkg::reg_sel_e reg_sel,
    output isa_pkg::alu_op_e   alu_op,
    output logic               y_in,
    output logic               z_in,
    output logic               hi_in,
    output logic               lo_in,
    output logic               pc_in,
    output logic               inc_pc,
    output logic               mar_in,
    output logic               mdr_in,
    output logic               mdr_read,
    output logic               reg_in,
    output logic               ir_in,
    output logic               con_in,
    output logic               out_in,
    output logic               ba_out,
    output logic               halted
);

    ctrl_pkg::ctrl_state_e state;
    ctrl_pkg::ctrl_state_e next_state;
    isa_pkg::alu_op_e      op_alu;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ctrl_pkg::fetch_req;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (opcode)
            isa_pkg::op_sub:                  op_alu = isa_pkg::alu_sub;
            isa_pkg::op_and, isa_pkg::op_andi: op_alu = isa_pkg::alu_and;
            isa_pkg::op_or, isa_pkg::op_ori:   op_alu = isa_pkg::alu_or;
            isa_pkg::op_shl:                  op_alu = isa_pkg::alu_shl;
            isa_pkg::op_shr:                  op_alu = isa_pkg::alu_shr;
            isa_pkg::op_shra:                 op_alu = isa_pkg::alu_shra;
            isa_pkg::op_mul:                  op_alu = isa_pkg::alu_mul;
            isa_pkg::op_neg:                  op_alu = isa_pkg::alu_neg;
            isa_pkg::op_not:                  op_alu = isa_pkg::alu_not;
            default:                          op_alu = isa_pkg::alu_add; // also addresses
        endcase
    end

    // bus cycle is open only in the two wait states
    assign wb_cyc = (state == ctrl_pkg::fetch_wait) || (state == ctrl_pkg::mem_wait);
    assign wb_stb = wb_cyc;
    assign wb_we  = (state == ctrl_pkg::mem_wait) && (opcode == isa_pkg::op_st);
    assign halted = (state == ctrl_pkg::halted);

    always_comb begin
        next_state = state;
        bus_src    = ctrl_pkg::src_reg;
        reg_sel    = ctrl_pkg::sel_ra;
        alu_op     = isa_pkg::alu_pass_b;
        y_in       = 1'b0;
        z_in       = 1'b0;
        hi_in      = 1'b0;
        lo_in      = 1'b0;
        pc_in      = 1'b0;
        inc_pc     = 1'b0;
        mar_in     = 1'b0;
        mdr_in     = 1'b0;
        mdr_read   = 1'b0;
        reg_in     = 1'b0;
        ir_in      = 1'b0;
        con_in     = 1'b0;
        out_in     = 1'b0;
        ba_out     = 1'b0;
        case (state)
            ctrl_pkg::fetch_req: begin
                bus_src    = ctrl_pkg::src_pc;
                mar_in     = 1'b1;
                inc_pc     = 1'b1;
                next_state = ctrl_pkg::fetch_wait;
            end
            ctrl_pkg::fetch_wait: begin
                mdr_read = 1'b1;
                mdr_in   = wb_ack;
                if (wb_ack) next_state = ctrl_pkg::decode;
            end
            ctrl_pkg::decode: begin
                bus_src    = ctrl_pkg::src_mdr;
                ir_in      = 1'b1;
                next_state = ctrl_pkg::exec_a;
            end
            ctrl_pkg::exec_a: begin
                next_state = ctrl_pkg::exec_b;
                case (opcode)
                    isa_pkg::op_mfhi, isa_pkg::op_mflo: begin
                        bus_src    = (opcode == isa_pkg::op_mfhi) ? ctrl_pkg::src_hi
                                                                  : ctrl_pkg::src_lo;
                        reg_in     = 1'b1;
                        next_state = ctrl_pkg::fetch_req;
                    end
                    isa_pkg::op_out: begin
                        out_in     = 1'b1;
                        next_state = ctrl_pkg::fetch_req;
                    end
                    isa_pkg::op_brzr, isa_pkg::op_brnz: con_in = 1'b1;
                    isa_pkg::op_halt: next_state = ctrl_pkg::halted;
                    isa_pkg::op_ld, isa_pkg::op_st: begin
                        reg_sel = ctrl_pkg::sel_rb;
                        ba_out  = 1'b1;
                        y_in    = 1'b1;
                    end
                    isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_or,
                    isa_pkg::op_shl, isa_pkg::op_shr, isa_pkg::op_shra, isa_pkg::op_mul,
                    isa_pkg::op_neg, isa_pkg::op_not, isa_pkg::op_addi, isa_pkg::op_andi,
                    isa_pkg::op_ori: begin
                        reg_sel = ctrl_pkg::sel_rb;
                        y_in    = 1'b1;
                    end
                    default: next_state = ctrl_pkg::fetch_req; // unused opcodes act as nop
                endcase
            end
            ctrl_pkg::exec_b: begin
                next_state = ctrl_pkg::exec_c;
                alu_op     = op_alu;
                z_in       = 1'b1;
                case (opcode)
                    isa_pkg::op_brzr, isa_pkg::op_brnz: begin
                        bus_src = ctrl_pkg::src_pc;  // PC already points past the branch
                        y_in    = 1'b1;
                        z_in    = 1'b0;
                    end
                    isa_pkg::op_addi, isa_pkg::op_andi, isa_pkg::op_ori,
                    isa_pkg::op_ld, isa_pkg::op_st: bus_src = ctrl_pkg::src_imm;
                    isa_pkg::op_neg, isa_pkg::op_not: reg_sel = ctrl_pkg::sel_rb;
                    default: reg_sel = ctrl_pkg::sel_rc;
                endcase
            end
            ctrl_pkg::exec_c: begin
                next_state = ctrl_pkg::fetch_req;
                bus_src    = ctrl_pkg::src_zlo;
                case (opcode)
                    isa_pkg::op_brzr, isa_pkg::op_brnz: begin
                        bus_src = ctrl_pkg::src_imm;
                        alu_op  = isa_pkg::alu_add;
                        z_in    = 1'b1;
                        if (con_flag) next_state = ctrl_pkg::write_back;
                    end
                    isa_pkg::op_ld: begin
                        mar_in     = 1'b1;
                        next_state = ctrl_pkg::mem_wait;
                    end
                    isa_pkg::op_st: begin
                        mar_in     = 1'b1;
                        next_state = ctrl_pkg::mem_req;
                    end
                    isa_pkg::op_mul: begin
                        lo_in      = 1'b1;
                        next_state = ctrl_pkg::write_back;
                    end
                    default: reg_in = 1'b1;
                endcase
            end
            ctrl_pkg::mem_req: begin
                mdr_in     = 1'b1;  // store data from ra
                next_state = ctrl_pkg::mem_wait;
            end
            ctrl_pkg::mem_wait: begin
                mdr_read = 1'b1;
                mdr_in   = wb_ack && (opcode == isa_pkg::op_ld);
                if (wb_ack) begin
                    next_state = (opcode == isa_pkg::op_ld) ? ctrl_pkg::write_back
                                                            : ctrl_pkg::fetch_req;
                end
            end
            ctrl_pkg::write_back: begin
                next_state = ctrl_pkg::fetch_req;
                case (opcode)
                    isa_pkg::op_ld: begin
                        bus_src = ctrl_pkg::src_mdr;
                        reg_in  = 1'b1;
                    end
                    isa_pkg::op_mul: begin
                        bus_src = ctrl_pkg::src_zhi;
                        hi_in   = 1'b1;
                    end
                    default: begin
                        bus_src = ctrl_pkg::src_zlo;  // taken branch target
                        pc_in   = 1'b1;
                    end
                endcase
            end
            default: next_state = ctrl_pkg::halted;
        endcase
    end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  logic        clock,
    input  logic        rst_n,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack,
    output logic [31:0] out_data,
    output logic        out_strobe,
    output logic        halted
);

    isa_pkg::opcode_e   opcode;
    isa_pkg::alu_op_e   alu_op;
    ctrl_pkg::bus_src_e bus_src;
    ctrl_pkg::reg_sel_e reg_sel;
    logic               con_flag;
    logic               y_in;
    logic               z_in;
    logic               hi_in;
    logic               lo_in;
    logic               pc_in;
    logic               inc_pc;
    logic               mar_in;
    logic               mdr_in;
    logic               mdr_read;
    logic               reg_in;
    logic               ir_in;
    logic               con_in;
    logic               ba_out;
    logic [31:0]        bus;
    logic [3:0]         reg_idx;
    logic [31:0]        imm;

    control_unit i_control_unit (
        .clock, .rst_n, .opcode, .con_flag, .wb_ack,
        .wb_cyc, .wb_stb, .wb_we, .bus_src, .reg_sel, .alu_op,
        .y_in, .z_in, .hi_in, .lo_in, .pc_in, .inc_pc, .mar_in, .mdr_in, .mdr_read,
        .reg_in, .ir_in, .con_in, .ba_out, .halted,
        .out_in (out_strobe)
    );

    ir_decode i_ir_decode (
        .clock, .rst_n, .ir_in, .bus, .reg_sel, .con_in,
        .opcode, .reg_idx, .imm, .con_flag
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clock, .rst_n, .bus_src,
        .y_in, .z_in, .hi_in, .lo_in, .pc_in, .inc_pc, .mar_in, .mdr_in, .mdr_read,
        .reg_in, .ba_out, .alu_op, .reg_idx, .imm, .wb_dat_i,
        .out_in (out_strobe),
        .bus, .wb_adr, .wb_dat_o, .out_data
    );

endmodule

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [3:0] {
        fetch_req,
        fetch_wait,
        decode,
        exec_a,
        exec_b,
        exec_c,
        mem_req,
        mem_wait,
        write_back,
        halted
    } ctrl_state_e;

    // what drives the shared bus this cycle
    typedef enum logic [2:0] {
        src_reg,
        src_pc,
        src_mdr,
        src_zlo,
        src_zhi,
        src_hi,
        src_lo,
        src_imm
    } bus_src_e;

    typedef enum logic [1:0] {
        sel_ra,
        sel_rb,
        sel_rc
    } reg_sel_e;

endpackage

// ==== hdl/datapath.sv ====
`timescale 1ns/1ns

module datapath #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  logic               clock,
    input  logic               rst_n,
    input  ctrl_pkg::bus_src_e bus_src,
    input  logic               y_in,
    input  logic               z_in,
    input  logic               hi_in,
    input  logic               lo_in,
    input  logic               pc_in,
    input  logic               inc_pc,
    input  logic               mar_in,
    input  logic               mdr_in,
    input  logic               mdr_read,
    input  logic               reg_in,
    input  logic               out_in,
    input  logic               ba_out,
    input  isa_pkg::alu_op_e   alu_op,
    input  logic [3:0]         reg_idx,
    input  logic [31:0]        imm,
    input  logic [31:0]        wb_dat_i,
    output logic [31:0]        bus,
    output logic [31:0]        wb_adr,
    output logic [31:0]        wb_dat_o,
    output logic [31:0]        out_data
);

    logic [31:0] rd_data;
    logic [31:0] y;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] pc;
    logic [31:0] mar;
    logic [31:0] mdr;
    logic [63:0] z;
    logic [63:0] alu_c;

    register_file i_register_file (
        .clock, .rst_n, .reg_in, .reg_idx, .ba_out, .bus, .rd_data
    );

    alu i_alu (
        .alu_op,
        .a (y),
        .b (bus),
        .c (alu_c)
    );

    always_comb begin
        case (bus_src)
            ctrl_pkg::src_reg: bus = rd_data;
            ctrl_pkg::src_pc:  bus = pc;
            ctrl_pkg::src_mdr: bus = mdr;
            ctrl_pkg::src_zlo: bus = z[31:0];
            ctrl_pkg::src_zhi: bus = z[63:32];
            ctrl_pkg::src_hi:  bus = hi;
            ctrl_pkg::src_lo:  bus = lo;
            default:           bus = imm;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            hi       <= '0;
            lo       <= '0;
            out_data <= '0;
        end else begin
            if (pc_in) begin
                pc <= bus;
            end else if (inc_pc) begin
                pc <= pc + 32'd1;
            end
            if (hi_in) hi <= bus;
            if (lo_in) lo <= bus;
            if (out_in) out_data <= bus;
        end
    end

    always_ff @(posedge clock) begin
        if (y_in) y <= bus;
        if (z_in) z <= alu_c;
        if (mar_in) mar <= bus;
        if (mdr_in) mdr <= mdr_read ? wb_dat_i : bus;  // read data or store data
    end

    assign wb_adr   = mar;
    assign wb_dat_o = mdr;

endmodule

// ==== hdl/ir_decode.sv ====
`timescale 1ns/1ns

module ir_decode (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               ir_in,
    input  logic [31:0]        bus,
    input  ctrl_pkg::reg_sel_e reg_sel,
    input  logic               con_in,
    output isa_pkg::opcode_e   opcode,
    output logic [3:0]         reg_idx,
    output logic [31:0]        imm,
    output logic               con_flag
);

    logic [31:0] ir;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ir_in) begin
            ir <= bus;
        end
    end

    assign opcode = isa_pkg::opcode_e'(ir[isa_pkg::opc_msb:isa_pkg::opc_lsb]);

    always_comb begin
        case (reg_sel)
            ctrl_pkg::sel_ra: reg_idx = ir[isa_pkg::ra_msb:isa_pkg::ra_lsb];
            ctrl_pkg::sel_rb: reg_idx = ir[isa_pkg::rb_msb:isa_pkg::rb_lsb];
            default:          reg_idx = ir[isa_pkg::rc_msb:isa_pkg::rc_lsb];
        endcase
    end

    assign imm = {{(32 - isa_pkg::imm_width){ir[isa_pkg::imm_msb]}},
                  ir[isa_pkg::imm_msb:isa_pkg::imm_lsb]};

    // branch condition sampled while ra is on the bus
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            con_flag <= 1'b0;
        end else if (con_in) begin
            case (opcode)
                isa_pkg::op_brzr: con_flag <= (bus == 32'd0);
                isa_pkg::op_brnz: con_flag <= (bus != 32'd0);
                default:          con_flag <= 1'b0;
            endcase
        end
    end

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_shl  = 5'd4,
        op_shr  = 5'd5,
        op_shra = 5'd6,
        op_mul  = 5'd7,
        op_neg  = 5'd8,
        op_not  = 5'd9,
        op_addi = 5'd10,
        op_andi = 5'd11,
        op_ori  = 5'd12,
        op_ld   = 5'd13,
        op_st   = 5'd14,
        op_brzr = 5'd15,
        op_brnz = 5'd16,
        op_mfhi = 5'd17,
        op_mflo = 5'd18,
        op_out  = 5'd19,
        op_halt = 5'd20
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_shl    = 4'd4,
        alu_shr    = 4'd5,
        alu_shra   = 4'd6,
        alu_mul    = 4'd7,
        alu_neg    = 4'd8,
        alu_not    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // field positions in the instruction word
    localparam int opc_msb   = 31;
    localparam int opc_lsb   = 27;
    localparam int ra_msb    = 26;
    localparam int ra_lsb    = 23;
    localparam int rb_msb    = 22;
    localparam int rb_lsb    = 19;
    localparam int rc_msb    = 18;
    localparam int rc_lsb    = 15;
    localparam int imm_msb   = 18; // C overlaps rc
    localparam int imm_lsb   = 0;
    localparam int imm_width = imm_msb - imm_lsb + 1;

endpackage

// ==== hdl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        reg_in,
    input  logic [3:0]  reg_idx,
    input  logic        ba_out,
    input  logic [31:0] bus,
    output logic [31:0] rd_data
);

    logic [31:0] regs [16];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_in) begin
            regs[reg_idx] <= bus;
        end
    end

    // r0 is a constant zero only when used as a base
    assign rd_data = (ba_out && reg_idx == 4'd0) ? 32'd0 : regs[reg_idx];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -Mdir obj_dir -f flist.f \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1 || echo "simulation exited with an error status"
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// ==== tests/cpu_assert.sv ====
`timescale 1ns/1ns

module cpu_assert (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input logic                  wb_ack,
    input logic                  mar_in,
    input logic                  mdr_in,
    input logic                  out_in,
    input logic                  halted,
    input ctrl_pkg::ctrl_state_e state
);

    a_stb_in_cyc: assert property (@(posedge clock) disable iff (!rst_n)
        wb_stb |-> wb_cyc) else $error("wb_stb high outside a bus cycle");

    a_stb_held: assert property (@(posedge clock) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_we)) else $error("request dropped before ack");

    // MAR drives wb_adr and MDR drives wb_dat_o
    a_adr_held: assert property (@(posedge clock) disable iff (!rst_n)
        wb_stb |-> !mar_in && !(wb_we && mdr_in)) else $error("address or data moved in cycle");

    // the core waits in the same state until the memory acknowledges
    a_wait_held: assert property (@(posedge clock) disable iff (!rst_n)
        (state == ctrl_pkg::fetch_wait || state == ctrl_pkg::mem_wait) && !wb_ack
        |=> state == $past(state))
        else $error("wait state left before ack");

    a_out_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        out_in |=> !out_in) else $error("out_strobe longer than one cycle");

    a_halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted) else $error("halted fell");

endmodule

bind control_unit cpu_assert i_cpu_assert (
    .clock, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_ack, .mar_in, .mdr_in, .out_in,
    .halted, .state
);

// ==== tests/cpu_checker.sv ====
`timescale 1ns/1ns

module cpu_checker #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack,
    input  logic [31:0] out_data,
    input  logic        out_strobe,
    input  logic        halted,
    output int          errors
);

    logic [31:0] regs [16];
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] pc;
    logic        ld_pend;
    logic        st_pend;
    logic        out_pend;
    logic        out_cmp;
    logic        halt_exp;
    logic [3:0]  ld_reg;
    logic [31:0] ld_addr;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic [31:0] exp_out;

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // one instruction of the reference model
    function automatic void exec_ref(input logic [31:0] instr);
        isa_pkg::opcode_e   op;
        logic [3:0]         ra;
        logic [3:0]         rb;
        logic [31:0]        vb;
        logic [31:0]        vc;
        logic [31:0]        c;
        logic signed [31:0] sb;
        logic signed [63:0] prod;
        op = isa_pkg::opcode_e'(instr[isa_pkg::opc_msb:isa_pkg::opc_lsb]);
        ra = instr[isa_pkg::ra_msb:isa_pkg::ra_lsb];
        rb = instr[isa_pkg::rb_msb:isa_pkg::rb_lsb];
        vb = regs[rb];
        vc = regs[instr[isa_pkg::rc_msb:isa_pkg::rc_lsb]];
        c  = 32'($signed(instr[isa_pkg::imm_msb:isa_pkg::imm_lsb]));
        sb = vb;
        pc = pc + 32'd1;
        case (op)
            isa_pkg::op_add:  regs[ra] = vb + vc;
            isa_pkg::op_sub:  regs[ra] = vb - vc;
            isa_pkg::op_and:  regs[ra] = vb & vc;
            isa_pkg::op_or:   regs[ra] = vb | vc;
            isa_pkg::op_shl:  regs[ra] = vb << vc[4:0];
            isa_pkg::op_shr:  regs[ra] = vb >> vc[4:0];
            isa_pkg::op_shra: regs[ra] = sb >>> vc[4:0];
            isa_pkg::op_mul: begin
                prod = $signed({{32{vb[31]}}, vb}) * $signed({{32{vc[31]}}, vc});
                hi   = prod[63:32];
                lo   = prod[31:0];
            end
            isa_pkg::op_neg:  regs[ra] = ~vb + 32'd1;
            isa_pkg::op_not:  regs[ra] = ~vb;
            isa_pkg::op_addi: regs[ra] = vb + c;
            isa_pkg::op_andi: regs[ra] = vb & c;
            isa_pkg::op_ori:  regs[ra] = vb | c;
            isa_pkg::op_ld: begin
                ld_pend = 1'b1;
                ld_reg  = ra;
                ld_addr = ((rb == 4'd0) ? 32'd0 : vb) + c;
            end
            isa_pkg::op_st: begin
                st_pend = 1'b1;
                st_addr = ((rb == 4'd0) ? 32'd0 : vb) + c;
                st_data = regs[ra];
            end
            isa_pkg::op_brzr: if (regs[ra] == 32'd0) pc = pc + c;
            isa_pkg::op_brnz: if (regs[ra] != 32'd0) pc = pc + c;
            isa_pkg::op_mfhi: regs[ra] = hi;
            isa_pkg::op_mflo: regs[ra] = lo;
            isa_pkg::op_out: begin
                out_pend = 1'b1;
                exp_out  = regs[ra];
            end
            isa_pkg::op_halt: halt_exp = 1'b1;
            default: ;  // unused opcodes do nothing
        endcase
    endfunction

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] = '0;
            end
            hi       = '0;
            lo       = '0;
            pc       = RESET_PC;
            ld_pend  = 1'b0;
            st_pend  = 1'b0;
            out_pend = 1'b0;
            out_cmp  = 1'b0;
            halt_exp = 1'b0;
            errors   = 0;
        end else begin
            if (out_cmp) begin
                if (out_data !== exp_out) mismatch("out_data", out_data, exp_out);
                out_cmp = 1'b0;
            end
            if (out_strobe) begin
                if (!out_pend) protocol_error("out_strobe pulsed with no out instruction");
                out_pend = 1'b0;
                out_cmp  = 1'b1;  // port register is loaded on this edge
            end
            if (halted && !halt_exp) protocol_error("halted rose before a halt was fetched");
            if (halted && wb_cyc) protocol_error("a Wishbone cycle was opened after halt");
            if (wb_cyc && wb_stb && wb_ack) begin
                if (wb_we) begin
                    if (!st_pend) begin
                        protocol_error("Wishbone write with no st instruction pending");
                    end else begin
                        if (wb_adr !== st_addr) mismatch("store address", wb_adr, st_addr);
                        if (wb_dat_o !== st_data) mismatch("store data", wb_dat_o, st_data);
                    end
                    st_pend = 1'b0;
                end else if (ld_pend) begin
                    if (wb_adr !== ld_addr) mismatch("load address", wb_adr, ld_addr);
                    regs[ld_reg] = wb_dat_i;
                    ld_pend      = 1'b0;
                end else begin
                    if (halt_exp) protocol_error("instruction fetched after halt");
                    if (st_pend) protocol_error("st finished without a Wishbone write");
                    if (out_pend) protocol_error("out finished without an out_strobe pulse");
                    st_pend  = 1'b0;
                    out_pend = 1'b0;
                    if (wb_adr !== pc) mismatch("fetch address", wb_adr, pc);
                    exec_ref(wb_dat_i);
                end
            end
        end
    end

endmodule

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

    localparam logic [31:0] reset_pc   = 32'd0;
    localparam int          n_instr    = 200;
    localparam int          mem_words  = 1024;
    localparam int          data_base  = 512;
    localparam int          max_wait   = 3;
    // twelve steps per instruction at most plus a fetch and a data wait
    localparam int          max_cycles = n_instr * (12 + 2 * (max_wait + 1)) + 40;

    logic        clock;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [31:0] out_data;
    logic        out_strobe;
    logic        halted;
    logic [31:0] mem [mem_words];
    int          seed;
    int          errors;
    int          wait_cnt;
    logic        busy;

    cpu_top #(
        .RESET_PC (reset_pc)
    ) i_cpu_top (
        .clock, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_dat_i,
        .wb_ack, .out_data, .out_strobe, .halted
    );

    cpu_checker #(
        .RESET_PC (reset_pc)
    ) i_cpu_checker (
        .clock, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_dat_i,
        .wb_ack, .out_data, .out_strobe, .halted, .errors
    );

    always #4 clock = ~clock;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] encode(input isa_pkg::opcode_e op, input logic [3:0] ra,
                                           input logic [3:0] rb, input logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    task automatic build_program();
        int               pick;
        int               p;
        int               skip;
        logic [3:0]       ra;
        logic [3:0]       rb;
        logic [3:0]       rc;
        isa_pkg::opcode_e op;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h0051_7cc1;
        end
        // r1 to r15 while r0 is still zero and r0 last
        for (int r = 0; r < 16; r++) begin
            mem[r] = encode(isa_pkg::op_addi, 4'((r + 1) % 16), 4'd0, 19'(rand_below(1 << 19)));
        end
        p = 16;
        while (p < n_instr - 1) begin
            pick = rand_below(100);
            ra   = 4'(rand_below(16));
            rc   = 4'(rand_below(16));
            if (pick < 35) begin
                op     = isa_pkg::opcode_e'(5'(rand_below(10)));
                mem[p] = encode(op, ra, 4'(rand_below(16)), {rc, 15'd0});
            end else if (pick < 50) begin
                op     = isa_pkg::opcode_e'(5'(10 + rand_below(3)));
                mem[p] = encode(op, ra, 4'(rand_below(16)), 19'(rand_below(1 << 19)));
            end else if (pick < 70) begin
                op     = (pick < 60) ? isa_pkg::op_st : isa_pkg::op_ld;
                rb     = (pick < 60) ? 4'd0 : 4'(rand_below(16));  // stores keep an r0 base
                skip   = data_base + rand_below(mem_words - data_base);
                mem[p] = encode(op, ra, rb, 19'(skip));
            end else if (pick < 82) begin
                op     = (pick < 76) ? isa_pkg::op_brzr : isa_pkg::op_brnz;
                skip   = rand_below(5);
                if (skip > n_instr - 2 - p) begin
                    skip = n_instr - 2 - p;  // never past the halt
                end
                mem[p] = encode(op, ra, 4'd0, 19'(skip));
            end else if (pick < 88) begin
                mem[p] = encode(isa_pkg::op_mul, ra, 4'(rand_below(16)), {rc, 15'd0});
            end else if (pick < 94) begin
                op     = (pick < 91) ? isa_pkg::op_mfhi : isa_pkg::op_mflo;
                mem[p] = encode(op, ra, 4'd0, 19'd0);
            end else begin
                mem[p] = encode(isa_pkg::op_out, ra, 4'd0, 19'd0);
            end
            p++;
        end
        mem[n_instr - 1] = encode(isa_pkg::op_halt, 4'd0, 4'd0, 19'd0);
    endtask

    // Wishbone memory with 0 to max_wait wait states per cycle
    initial begin
        forever begin
            @(posedge clock);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
                busy   = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy     = 1'b1;
                    wait_cnt = rand_below(max_wait + 1);
                end
                if (wait_cnt == 0) begin
                    if (wb_we) begin
                        mem[wb_adr[9:0]] = wb_dat_o;
                    end else begin
                        wb_dat_i = mem[wb_adr[9:0]];
                    end
                    wb_ack = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    initial begin
        seed     = 19673;
        clock    = 1'b0;
        rst_n    = 1'b0;
        wb_dat_i = '0;
        wb_ack   = 1'b0;
        busy     = 1'b0;
        wait_cnt = 0;
        build_program();
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;
        wait (halted === 1'b1);
        repeat (20) @(posedge clock);  // bus must stay idle after halt
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(max_cycles * 8);
        $display("watchdog: core did not halt within %0d cycles, errors: %0d",
                 max_cycles, errors);
        $display("sim failed");
        $finish;
    end

endmodule
